//--- id_stage.f
+incdir+verif
src/mips_isa_pkg.sv
src/id_ctrl_pkg.sv
src/id_decoder.sv
src/id_operand_fwd.sv
src/id_branch_unit.sv
src/id_stage.sv
verif/id_stage_tb.sv

//--- src/id_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire branch_kind_e kind_i,
    input  wire               link_i,
    input  wire word_t        pc_i,
    input  wire inst_t        inst_i,
    input  wire word_t        rs_val_i,
    input  wire word_t        rt_val_i,
    output logic              branch_flag_o,
    output word_t             target_o,
    output word_t             link_addr_o
);

    word_t pc_plus_4;
    word_t br_offset;
    logic  taken;

    assign pc_plus_4 = pc_i + 32'd4;
    assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

    always_comb begin
        case (kind_i)
            BR_JUMP_ABS, BR_JUMP_REG: taken = 1'b1;
            BR_EQ:   taken = (rs_val_i == rt_val_i);
            BR_NE:   taken = (rs_val_i != rt_val_i);
            BR_GTZ:  taken = ($signed(rs_val_i) > 32'sd0);
            BR_LEZ:  taken = ($signed(rs_val_i) <= 32'sd0);
            BR_GEZ:  taken = ($signed(rs_val_i) >= 32'sd0);
            BR_LTZ:  taken = ($signed(rs_val_i) < 32'sd0);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken)
            target_o = '0;
        else if (kind_i == BR_JUMP_ABS)
            target_o = {pc_plus_4[31:28], inst_i[25:0], 2'b00};  // 256MB region
        else if (kind_i == BR_JUMP_REG)
            target_o = rs_val_i;
        else
            target_o = pc_plus_4 + br_offset;
    end

    assign branch_flag_o = taken;
    assign link_addr_o   = link_i ? pc_i + 32'd8 : '0;  // skip the delay slot

endmodule

`default_nettype wire

//--- src/id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [7:0] {
        ALU_NOP    = 8'b00000000,
        ALU_AND    = 8'b00100100,
        ALU_OR     = 8'b00100101,
        ALU_XOR    = 8'b00100110,
        ALU_NOR    = 8'b00100111,
        ALU_SLL    = 8'b01111100,
        ALU_SRL    = 8'b00000010,
        ALU_SRA    = 8'b00000011,
        ALU_MOVZ   = 8'b00001010,
        ALU_MOVN   = 8'b00001011,
        ALU_SLT    = 8'b00101010,
        ALU_SLTU   = 8'b00101011,
        ALU_ADDI   = 8'b01010101,
        ALU_ADDIU  = 8'b01010110,
        ALU_ADD    = 8'b00100000,
        ALU_ADDU   = 8'b00100001,
        ALU_SUB    = 8'b00100010,
        ALU_SUBU   = 8'b00100011,
        ALU_J      = 8'b01001111,
        ALU_JAL    = 8'b01010000,
        ALU_JR     = 8'b00001000,
        ALU_JALR   = 8'b00001001,
        ALU_BEQ    = 8'b01010001,
        ALU_BNE    = 8'b01010010,
        ALU_BGTZ   = 8'b01010100,
        ALU_BLEZ   = 8'b01010011,
        ALU_BGEZ   = 8'b01000001,
        ALU_BGEZAL = 8'b01001011,
        ALU_BLTZ   = 8'b01000000,
        ALU_BLTZAL = 8'b01001010
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_MOVE        = 3'b011,
        SEL_ARITHMETIC  = 3'b100,
        SEL_JUMP_BRANCH = 3'b110
    } alusel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JUMP_ABS, BR_JUMP_REG, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
    } branch_kind_e;

endpackage

`default_nettype wire

//--- src/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire inst_t         inst_i,
    input  wire word_t         reg2_val_i,   // forwarded rt for movn/movz
    output aluop_e             aluop_o,
    output alusel_e            alusel_o,
    output logic               wreg_o,
    output reg_addr_t          wd_o,
    output logic               reg1_read_o,
    output logic               reg2_read_o,
    output reg_addr_t          reg1_addr_o,
    output reg_addr_t          reg2_addr_o,
    output word_t              imm_o,
    output branch_kind_e       branch_kind_o,
    output logic               link_o
);

    opcode_e     op;
    funct_e      fn;
    regimm_e     ri;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    reg_addr_t   sa;
    logic [15:0] imm16;

    assign op    = opcode_e'(inst_i[31:26]);
    assign fn    = funct_e'(inst_i[5:0]);
    assign ri    = regimm_e'(inst_i[20:16]);
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign imm16 = inst_i[15:0];

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    function automatic aluop_e special_aluop(funct_e f);
        case (f)
            F_AND:          return ALU_AND;
            F_OR:           return ALU_OR;
            F_XOR:          return ALU_XOR;
            F_NOR:          return ALU_NOR;
            F_SLL, F_SLLV:  return ALU_SLL;
            F_SRL, F_SRLV:  return ALU_SRL;
            F_SRA, F_SRAV:  return ALU_SRA;
            F_MOVN:         return ALU_MOVN;
            F_MOVZ:         return ALU_MOVZ;
            F_SLT:          return ALU_SLT;
            F_SLTU:         return ALU_SLTU;
            F_ADD:          return ALU_ADD;
            F_ADDU:         return ALU_ADDU;
            F_SUB:          return ALU_SUB;
            F_SUBU:         return ALU_SUBU;
            F_JR:           return ALU_JR;
            F_JALR:         return ALU_JALR;
            default:        return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        aluop_o       = ALU_NOP;
        alusel_o      = SEL_NOP;
        wreg_o        = 1'b0;
        wd_o          = rd;
        reg1_read_o   = 1'b0;
        reg2_read_o   = 1'b0;
        imm_o         = '0;
        branch_kind_o = BR_NONE;
        link_o        = 1'b0;
        case (op)
            OP_SPECIAL: begin
                if (fn inside {F_SLL, F_SRL, F_SRA}) begin
                    if (rs == '0) begin
                        aluop_o     = special_aluop(fn);
                        alusel_o    = SEL_SHIFT;
                        wreg_o      = 1'b1;
                        reg2_read_o = 1'b1;
                        imm_o       = {27'b0, sa};  // shamt via reg1
                    end
                end else if (sa == '0) begin
                    aluop_o     = special_aluop(fn);
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    wreg_o      = 1'b1;
                    case (fn)
                        F_AND, F_OR, F_XOR, F_NOR:  alusel_o = SEL_LOGIC;
                        F_SLLV, F_SRLV, F_SRAV:     alusel_o = SEL_SHIFT;
                        F_SLT, F_SLTU, F_ADD, F_ADDU, F_SUB, F_SUBU: begin
                            alusel_o = SEL_ARITHMETIC;
                        end
                        F_MOVN, F_MOVZ: begin
                            alusel_o = SEL_MOVE;
                            wreg_o   = (reg2_val_i != '0) ^ (fn == F_MOVZ);
                        end
                        F_JR, F_JALR: begin
                            alusel_o      = SEL_JUMP_BRANCH;
                            reg2_read_o   = 1'b0;
                            branch_kind_o = BR_JUMP_REG;
                            link_o        = (fn == F_JALR);
                            wreg_o        = (fn == F_JALR);  // jalr links to rd
                        end
                        default: begin
                            reg1_read_o = 1'b0;
                            reg2_read_o = 1'b0;
                            wreg_o      = 1'b0;
                        end
                    endcase
                end
            end
            OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
                alusel_o    = SEL_LOGIC;
                wreg_o      = 1'b1;
                wd_o        = rt;
                reg1_read_o = 1'b1;
                imm_o       = (op == OP_LUI) ? {imm16, 16'h0} : {16'h0, imm16};
                aluop_o     = (op == OP_ANDI) ? ALU_AND : (op == OP_XORI) ? ALU_XOR : ALU_OR;
            end
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
                alusel_o    = SEL_ARITHMETIC;
                wreg_o      = 1'b1;
                wd_o        = rt;
                reg1_read_o = 1'b1;
                imm_o       = {{16{imm16[15]}}, imm16};
                case (op)
                    OP_SLTI:  aluop_o = ALU_SLT;
                    OP_SLTIU: aluop_o = ALU_SLTU;
                    OP_ADDI:  aluop_o = ALU_ADDI;
                    default:  aluop_o = ALU_ADDIU;
                endcase
            end
            OP_J, OP_JAL: begin
                aluop_o       = (op == OP_JAL) ? ALU_JAL : ALU_J;
                alusel_o      = SEL_JUMP_BRANCH;
                branch_kind_o = BR_JUMP_ABS;
                link_o        = (op == OP_JAL);
                wreg_o        = (op == OP_JAL);
                if (op == OP_JAL)
                    wd_o = LINK_REG;
            end
            OP_BEQ, OP_BNE: begin
                aluop_o       = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
                alusel_o      = SEL_JUMP_BRANCH;
                reg1_read_o   = 1'b1;
                reg2_read_o   = 1'b1;
                branch_kind_o = (op == OP_BEQ) ? BR_EQ : BR_NE;
            end
            OP_BGTZ, OP_BLEZ: begin
                aluop_o       = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
                alusel_o      = SEL_JUMP_BRANCH;
                reg1_read_o   = 1'b1;
                branch_kind_o = (op == OP_BGTZ) ? BR_GTZ : BR_LEZ;
            end
            OP_REGIMM: begin
                if (ri inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL}) begin
                    alusel_o      = SEL_JUMP_BRANCH;
                    reg1_read_o   = 1'b1;
                    branch_kind_o = (ri inside {RI_BGEZ, RI_BGEZAL}) ? BR_GEZ : BR_LTZ;
                    link_o        = (ri inside {RI_BLTZAL, RI_BGEZAL});
                    wreg_o        = link_o;  // links even when not taken
                    wd_o          = link_o ? LINK_REG : rd;
                    case (ri)
                        RI_BLTZ:   aluop_o = ALU_BLTZ;
                        RI_BGEZ:   aluop_o = ALU_BGEZ;
                        RI_BLTZAL: aluop_o = ALU_BLTZAL;
                        default:   aluop_o = ALU_BGEZAL;
                    endcase
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/id_operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand_fwd
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire            read_i,
    input  wire reg_addr_t addr_i,
    input  wire word_t     rf_data_i,
    input  wire word_t     imm_i,
    input  wire            ex_wreg_i,
    input  wire reg_addr_t ex_wd_i,
    input  wire word_t     ex_wdata_i,
    input  wire            mem_wreg_i,
    input  wire reg_addr_t mem_wd_i,
    input  wire word_t     mem_wdata_i,
    output word_t          operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

    // youngest result wins
    always_comb begin
        if (!read_i)
            operand_o = imm_i;
        else if (ex_hit)
            operand_o = ex_wdata_i;
        else if (mem_hit)
            operand_o = mem_wdata_i;
        else
            operand_o = rf_data_i;
    end

endmodule

`default_nettype wire

//--- src/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire            inst_valid_i,
    input  wire word_t     pc_i,
    input  wire inst_t     inst_i,
    input  wire            is_in_delayslot_i,
    input  wire word_t     rf_data1_i,
    input  wire word_t     rf_data2_i,
    input  wire            ex_wreg_i,
    input  wire reg_addr_t ex_wd_i,
    input  wire word_t     ex_wdata_i,
    input  wire            mem_wreg_i,
    input  wire reg_addr_t mem_wd_i,
    input  wire word_t     mem_wdata_i,
    output logic           rf_read1_o,
    output logic           rf_read2_o,
    output reg_addr_t      rf_addr1_o,
    output reg_addr_t      rf_addr2_o,
    output logic           ex_valid_o,
    output aluop_e         ex_aluop_o,
    output alusel_e        ex_alusel_o,
    output word_t          ex_reg1_o,
    output word_t          ex_reg2_o,
    output reg_addr_t      ex_wd_o,
    output logic           ex_wreg_o,
    output word_t          ex_link_addr_o,
    output logic           ex_is_in_delayslot_o,
    output logic           branch_flag_o,
    output word_t          branch_target_o,
    output logic           next_inst_in_delayslot_o
);

    aluop_e       aluop;
    alusel_e      alusel;
    logic         wreg;
    reg_addr_t    wd;
    word_t        imm;
    branch_kind_e kind;
    logic         link;
    word_t        reg1;
    word_t        reg2;
    logic         br_flag;
    word_t        br_target;
    word_t        link_addr;

    id_decoder u_decoder (
        .inst_i        (inst_i),
        .reg2_val_i    (reg2),
        .aluop_o       (aluop),
        .alusel_o      (alusel),
        .wreg_o        (wreg),
        .wd_o          (wd),
        .reg1_read_o   (rf_read1_o),
        .reg2_read_o   (rf_read2_o),
        .reg1_addr_o   (rf_addr1_o),
        .reg2_addr_o   (rf_addr2_o),
        .imm_o         (imm),
        .branch_kind_o (kind),
        .link_o        (link)
    );

    id_operand_fwd u_fwd1 (
        .read_i      (rf_read1_o),
        .addr_i      (rf_addr1_o),
        .rf_data_i   (rf_data1_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1)
    );

    id_operand_fwd u_fwd2 (
        .read_i      (rf_read2_o),
        .addr_i      (rf_addr2_o),
        .rf_data_i   (rf_data2_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2)
    );

    id_branch_unit u_branch (
        .kind_i        (kind),
        .link_i        (link),
        .pc_i          (pc_i),
        .inst_i        (inst_i),
        .rs_val_i      (reg1),
        .rt_val_i      (reg2),
        .branch_flag_o (br_flag),
        .target_o      (br_target),
        .link_addr_o   (link_addr)
    );

    // control half of the ID/EX register with bubble insertion
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o               <= 1'b0;
            ex_aluop_o               <= ALU_NOP;
            ex_alusel_o              <= SEL_NOP;
            ex_wreg_o                <= 1'b0;
            ex_is_in_delayslot_o     <= 1'b0;
            branch_flag_o            <= 1'b0;
            next_inst_in_delayslot_o <= 1'b0;
        end else begin
            ex_valid_o               <= inst_valid_i;
            ex_aluop_o               <= inst_valid_i ? aluop : ALU_NOP;
            ex_alusel_o              <= inst_valid_i ? alusel : SEL_NOP;
            ex_wreg_o                <= inst_valid_i & wreg;
            ex_is_in_delayslot_o     <= is_in_delayslot_i;
            branch_flag_o            <= inst_valid_i & br_flag;
            next_inst_in_delayslot_o <= inst_valid_i & br_flag;  // next fetch is the slot
        end
    end

    always_ff @(posedge clk) begin
        ex_reg1_o       <= reg1;
        ex_reg2_o       <= reg2;
        ex_wd_o         <= wd;
        ex_link_addr_o  <= link_addr;
        branch_target_o <= br_target;
    end

endmodule

`default_nettype wire

//--- src/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t LINK_REG = 5'd31;  // $ra

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function field of OP_SPECIAL
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_JR   = 6'b001000,
        F_JALR = 6'b001001,
        F_MOVZ = 6'b001010,
        F_MOVN = 6'b001011,
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_e;

endpackage

`default_nettype wire

//--- verif/id_model.svh
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// expected state of the ID/EX register plus the combinational read enables
typedef struct packed {
    logic       valid;
    logic [7:0] aluop;
    logic [2:0] alusel;
    logic       wreg;
    reg_addr_t  wd;
    logic       rd1;
    logic       rd2;
    word_t      reg1;
    word_t      reg2;
    word_t      link_addr;
    logic       br_flag;
    word_t      target;
    logic       dslot;
} expect_t;

// youngest producer first, register file last
function automatic word_t operand_of(logic rd_en, reg_addr_t a, word_t rf, word_t imm);
    if (!rd_en)
        return imm;
    if (ex_wreg_i && ex_wd_i == a)
        return ex_wdata_i;
    if (mem_wreg_i && mem_wd_i == a)
        return mem_wdata_i;
    return rf;
endfunction

// expected outputs for the inputs currently applied to the DUT
function automatic expect_t predict();
    expect_t      e;
    logic [5:0]   op;
    logic [5:0]   fn;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    rd;
    reg_addr_t    sa;
    logic [15:0]  imm16;
    word_t        imm;
    word_t        pc4;
    branch_kind_e kind;
    logic         link;
    logic         cshift;
    op     = inst_i[31:26];
    fn     = inst_i[5:0];
    rs     = inst_i[25:21];
    rt     = inst_i[20:16];
    rd     = inst_i[15:11];
    sa     = inst_i[10:6];
    imm16  = inst_i[15:0];
    e      = '0;
    e.aluop  = ALU_NOP;
    e.alusel = SEL_NOP;
    e.wd     = rd;
    imm    = '0;
    kind   = BR_NONE;
    link   = 1'b0;
    cshift = (fn == F_SLL || fn == F_SRL || fn == F_SRA);
    case (op)
        OP_SPECIAL: begin
            if (cshift ? (rs == 5'd0) : (sa == 5'd0)) begin
                e.wreg = 1'b1;
                e.rd1  = !cshift;  // constant shift takes sa as reg1
                e.rd2  = 1'b1;
                if (cshift)
                    imm = {27'b0, sa};
                case (fn)
                    F_AND:         {e.aluop, e.alusel} = {ALU_AND, SEL_LOGIC};
                    F_OR:          {e.aluop, e.alusel} = {ALU_OR, SEL_LOGIC};
                    F_XOR:         {e.aluop, e.alusel} = {ALU_XOR, SEL_LOGIC};
                    F_NOR:         {e.aluop, e.alusel} = {ALU_NOR, SEL_LOGIC};
                    F_SLL, F_SLLV: {e.aluop, e.alusel} = {ALU_SLL, SEL_SHIFT};
                    F_SRL, F_SRLV: {e.aluop, e.alusel} = {ALU_SRL, SEL_SHIFT};
                    F_SRA, F_SRAV: {e.aluop, e.alusel} = {ALU_SRA, SEL_SHIFT};
                    F_SLT:         {e.aluop, e.alusel} = {ALU_SLT, SEL_ARITHMETIC};
                    F_SLTU:        {e.aluop, e.alusel} = {ALU_SLTU, SEL_ARITHMETIC};
                    F_ADD:         {e.aluop, e.alusel} = {ALU_ADD, SEL_ARITHMETIC};
                    F_ADDU:        {e.aluop, e.alusel} = {ALU_ADDU, SEL_ARITHMETIC};
                    F_SUB:         {e.aluop, e.alusel} = {ALU_SUB, SEL_ARITHMETIC};
                    F_SUBU:        {e.aluop, e.alusel} = {ALU_SUBU, SEL_ARITHMETIC};
                    F_MOVN:        {e.aluop, e.alusel} = {ALU_MOVN, SEL_MOVE};
                    F_MOVZ:        {e.aluop, e.alusel} = {ALU_MOVZ, SEL_MOVE};
                    F_JR, F_JALR: begin
                        e.aluop  = (fn == F_JALR) ? ALU_JALR : ALU_JR;
                        e.alusel = SEL_JUMP_BRANCH;
                        e.rd2    = 1'b0;
                        e.wreg   = (fn == F_JALR);
                        kind     = BR_JUMP_REG;
                        link     = (fn == F_JALR);
                    end
                    default: begin
                        e.wreg = 1'b0;
                        e.rd1  = 1'b0;
                        e.rd2  = 1'b0;
                    end
                endcase
            end
        end
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            e.alusel = SEL_LOGIC;
            e.wreg   = 1'b1;
            e.wd     = rt;
            e.rd1    = 1'b1;
            imm      = (op == OP_LUI) ? {imm16, 16'h0000} : {16'h0000, imm16};
            if (op == OP_ANDI)
                e.aluop = ALU_AND;
            else if (op == OP_XORI)
                e.aluop = ALU_XOR;
            else
                e.aluop = ALU_OR;  // lui is an or with zero
        end
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
            e.alusel = SEL_ARITHMETIC;
            e.wreg   = 1'b1;
            e.wd     = rt;
            e.rd1    = 1'b1;
            imm      = {{16{imm16[15]}}, imm16};
            case (op)
                OP_ADDI:  e.aluop = ALU_ADDI;
                OP_ADDIU: e.aluop = ALU_ADDIU;
                OP_SLTI:  e.aluop = ALU_SLT;
                default:  e.aluop = ALU_SLTU;
            endcase
        end
        OP_J, OP_JAL: begin
            e.aluop  = (op == OP_JAL) ? ALU_JAL : ALU_J;
            e.alusel = SEL_JUMP_BRANCH;
            kind     = BR_JUMP_ABS;
            link     = (op == OP_JAL);
            e.wreg   = link;
            if (link)
                e.wd = LINK_REG;
        end
        OP_BEQ, OP_BNE: begin
            e.aluop  = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
            e.alusel = SEL_JUMP_BRANCH;
            e.rd1    = 1'b1;
            e.rd2    = 1'b1;
            kind     = (op == OP_BEQ) ? BR_EQ : BR_NE;
        end
        OP_BGTZ, OP_BLEZ: begin
            e.aluop  = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
            e.alusel = SEL_JUMP_BRANCH;
            e.rd1    = 1'b1;
            kind     = (op == OP_BGTZ) ? BR_GTZ : BR_LEZ;
        end
        OP_REGIMM: begin
            if (rt == RI_BLTZ || rt == RI_BGEZ || rt == RI_BLTZAL || rt == RI_BGEZAL) begin
                e.alusel = SEL_JUMP_BRANCH;
                e.rd1    = 1'b1;
                kind     = (rt == RI_BGEZ || rt == RI_BGEZAL) ? BR_GEZ : BR_LTZ;
                link     = (rt == RI_BLTZAL || rt == RI_BGEZAL);
                e.wreg   = link;
                if (link)
                    e.wd = LINK_REG;
                case (rt)
                    RI_BLTZ:   e.aluop = ALU_BLTZ;
                    RI_BGEZ:   e.aluop = ALU_BGEZ;
                    RI_BLTZAL: e.aluop = ALU_BLTZAL;
                    default:   e.aluop = ALU_BGEZAL;
                endcase
            end
        end
        default: ;
    endcase
    e.reg1 = operand_of(e.rd1, rs, rf_data1_i, imm);
    e.reg2 = operand_of(e.rd2, rt, rf_data2_i, imm);
    if (e.aluop == ALU_MOVN)
        e.wreg = (e.reg2 != 32'd0);
    if (e.aluop == ALU_MOVZ)
        e.wreg = (e.reg2 == 32'd0);
    case (kind)
        BR_JUMP_ABS, BR_JUMP_REG: e.br_flag = 1'b1;
        BR_EQ:   e.br_flag = (e.reg1 == e.reg2);
        BR_NE:   e.br_flag = (e.reg1 != e.reg2);
        BR_GTZ:  e.br_flag = ($signed(e.reg1) > 0);
        BR_LEZ:  e.br_flag = ($signed(e.reg1) <= 0);
        BR_GEZ:  e.br_flag = ($signed(e.reg1) >= 0);
        BR_LTZ:  e.br_flag = ($signed(e.reg1) < 0);
        default: e.br_flag = 1'b0;
    endcase
    pc4 = pc_i + 32'd4;
    if (e.br_flag) begin
        if (kind == BR_JUMP_ABS)
            e.target = {pc4[31:28], inst_i[25:0], 2'b00};
        else if (kind == BR_JUMP_REG)
            e.target = e.reg1;
        else
            e.target = pc4 + {{14{imm16[15]}}, imm16, 2'b00};
    end
    e.link_addr = link ? pc_i + 32'd8 : 32'd0;
    e.valid     = inst_valid_i;
    e.dslot     = is_in_delayslot_i;
    if (!inst_valid_i) begin  // bubble
        e.aluop   = ALU_NOP;
        e.alusel  = SEL_NOP;
        e.wreg    = 1'b0;
        e.br_flag = 1'b0;
    end
    return e;
endfunction

`endif

//--- verif/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
();

    localparam int NUM_VECTORS    = 2000;
    localparam int TIMEOUT_CYCLES = NUM_VECTORS + 100;
    localparam logic [17*6-1:0] R_FUNCTS = {F_SLLV, F_SRLV, F_SRAV, F_JR, F_JALR, F_MOVZ,
        F_MOVN, F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU};
    localparam logic [3*6-1:0]  SHIFT_FUNCTS = {F_SLL, F_SRL, F_SRA};
    localparam logic [4*5-1:0]  RI_CODES = {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL};

    logic      clk;
    logic      arst_n_i;
    logic      inst_valid_i;
    word_t     pc_i;
    inst_t     inst_i;
    logic      is_in_delayslot_i;
    word_t     rf_data1_i;
    word_t     rf_data2_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;
    logic      rf_read1_o;
    logic      rf_read2_o;
    reg_addr_t rf_addr1_o;
    reg_addr_t rf_addr2_o;
    logic      ex_valid_o;
    aluop_e    ex_aluop_o;
    alusel_e   ex_alusel_o;
    word_t     ex_reg1_o;
    word_t     ex_reg2_o;
    reg_addr_t ex_wd_o;
    logic      ex_wreg_o;
    word_t     ex_link_addr_o;
    logic      ex_is_in_delayslot_o;
    logic      branch_flag_o;
    word_t     branch_target_o;
    logic      next_inst_in_delayslot_o;

    integer seed;
    int     errors;
    int     checks;
    int     cycle_cnt;

    `include "id_model.svh"

    expect_t exp_q[$];

    id_stage DUT (
        .clk                      (clk),
        .arst_n_i                 (arst_n_i),
        .inst_valid_i             (inst_valid_i),
        .pc_i                     (pc_i),
        .inst_i                   (inst_i),
        .is_in_delayslot_i        (is_in_delayslot_i),
        .rf_data1_i               (rf_data1_i),
        .rf_data2_i               (rf_data2_i),
        .ex_wreg_i                (ex_wreg_i),
        .ex_wd_i                  (ex_wd_i),
        .ex_wdata_i               (ex_wdata_i),
        .mem_wreg_i               (mem_wreg_i),
        .mem_wd_i                 (mem_wd_i),
        .mem_wdata_i              (mem_wdata_i),
        .rf_read1_o               (rf_read1_o),
        .rf_read2_o               (rf_read2_o),
        .rf_addr1_o               (rf_addr1_o),
        .rf_addr2_o               (rf_addr2_o),
        .ex_valid_o               (ex_valid_o),
        .ex_aluop_o               (ex_aluop_o),
        .ex_alusel_o              (ex_alusel_o),
        .ex_reg1_o                (ex_reg1_o),
        .ex_reg2_o                (ex_reg2_o),
        .ex_wd_o                  (ex_wd_o),
        .ex_wreg_o                (ex_wreg_o),
        .ex_link_addr_o           (ex_link_addr_o),
        .ex_is_in_delayslot_o     (ex_is_in_delayslot_o),
        .branch_flag_o            (branch_flag_o),
        .branch_target_o          (branch_target_o),
        .next_inst_in_delayslot_o (next_inst_in_delayslot_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s at %0t: expected %h, actual %h", name, $time, expected, actual);
        end
    endtask

    // zero and small negative values are common so branch conditions flip often
    function automatic word_t rand_data();
        case ({$random(seed)} % 4)
            0:       return 32'd0;
            1:       return 32'hffff_ffff - ({$random(seed)} % 8);
            2:       return 32'd1 + ({$random(seed)} % 8);
            default: return $random(seed);
        endcase
    endfunction

    function automatic inst_t make_inst();
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        reg_addr_t   sa;
        logic [15:0] imm;
        logic [25:0] idx;
        logic [5:0]  bad_op;
        logic [2:0]  sub;
        int          pick;
        rs     = {$random(seed)} % 8;  // small range for forwarding hits
        rt     = {$random(seed)} % 8;
        rd     = $random(seed);
        sa     = $random(seed);
        imm    = $random(seed);
        idx    = $random(seed);
        bad_op = 6'd16 + ({$random(seed)} % 48);
        sub    = $random(seed);
        case ({$random(seed)} % 8)
            0: return {bad_op, idx};
            1: begin
                pick = {$random(seed)} % 3;
                return {6'b000000, 5'd0, rt, rd, sa, SHIFT_FUNCTS[pick*6 +: 6]};
            end
            2, 3: begin
                pick = {$random(seed)} % 17;
                return {6'b000000, rs, rt, rd, 5'd0, R_FUNCTS[pick*6 +: 6]};
            end
            4: return {3'b001, sub, rs, rt, imm};
            5: return {5'b00001, sub[0], idx};
            6: return {4'b0001, sub[1:0], rs, rt, imm};
            default: begin
                pick = {$random(seed)} % 4;
                return {OP_REGIMM, rs, RI_CODES[pick*5 +: 5], imm};
            end
        endcase
    endfunction

    task automatic drive_vector();
        inst_valid_i      = ({$random(seed)} % 10) != 0;
        pc_i              = $random(seed) & 32'hffff_fffc;
        inst_i            = make_inst();
        is_in_delayslot_i = $random(seed);
        rf_data1_i        = rand_data();
        rf_data2_i        = rand_data();
        ex_wreg_i         = $random(seed);
        ex_wd_i           = {$random(seed)} % 8;
        ex_wdata_i        = rand_data();
        mem_wreg_i        = $random(seed);
        mem_wd_i          = {$random(seed)} % 8;
        mem_wdata_i       = rand_data();
    endtask

    task automatic compare_outputs(expect_t e);
        compare_value("ex_valid_o", e.valid, ex_valid_o);
        compare_value("ex_aluop_o", e.aluop, ex_aluop_o);
        compare_value("ex_alusel_o", e.alusel, ex_alusel_o);
        compare_value("ex_wreg_o", e.wreg, ex_wreg_o);
        compare_value("branch_flag_o", e.br_flag, branch_flag_o);
        compare_value("next_inst_in_delayslot_o", e.br_flag, next_inst_in_delayslot_o);
        compare_value("ex_is_in_delayslot_o", e.dslot, ex_is_in_delayslot_o);
        if (e.valid) begin
            compare_value("ex_reg1_o", e.reg1, ex_reg1_o);
            compare_value("ex_reg2_o", e.reg2, ex_reg2_o);
            compare_value("ex_wd_o", e.wd, ex_wd_o);
            compare_value("ex_link_addr_o", e.link_addr, ex_link_addr_o);
            compare_value("branch_target_o", e.target, branch_target_o);
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run still busy after %0d clock cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        expect_t e;
        seed              = 32'h9831190e;
        errors            = 0;
        checks            = 0;
        arst_n_i          = 1'b0;
        inst_valid_i      = 1'b0;
        pc_i              = '0;
        inst_i            = '0;
        is_in_delayslot_i = 1'b0;
        rf_data1_i        = '0;
        rf_data2_i        = '0;
        ex_wreg_i         = 1'b0;
        ex_wd_i           = '0;
        ex_wdata_i        = '0;
        mem_wreg_i        = 1'b0;
        mem_wd_i          = '0;
        mem_wdata_i       = '0;
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;
        compare_value("ex_valid_o", 1'b0, ex_valid_o);  // reset values
        compare_value("ex_aluop_o", ALU_NOP, ex_aluop_o);
        compare_value("ex_wreg_o", 1'b0, ex_wreg_o);
        compare_value("branch_flag_o", 1'b0, branch_flag_o);
        compare_value("next_inst_in_delayslot_o", 1'b0, next_inst_in_delayslot_o);
        compare_value("ex_is_in_delayslot_o", 1'b0, ex_is_in_delayslot_o);
        for (int n = 0; n < NUM_VECTORS; n++) begin
            if (n > 0) begin
                @(negedge clk);
                compare_outputs(exp_q.pop_front());
            end
            drive_vector();
            #1;
            e = predict();
            compare_value("rf_read1_o", e.rd1, rf_read1_o);
            compare_value("rf_read2_o", e.rd2, rf_read2_o);
            compare_value("rf_addr1_o", inst_i[25:21], rf_addr1_o);
            compare_value("rf_addr2_o", inst_i[20:16], rf_addr2_o);
            exp_q.push_back(e);
        end
        @(negedge clk);
        compare_outputs(exp_q.pop_front());
        $display("vectors: %0d, checks: %0d, errors: %0d", NUM_VECTORS, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
